//--- rtl/decodePkg.sv
// Shared opcodes, function codes, ALU codes and the instruction word views of the decode stage
package decodePkg;

	// ====================
	// Field widths
	// ====================

	// Width of every register specifier in the instruction word
	localparam int REG_BITS = 5;

	// ====================
	// Primary opcodes
	// ====================

	// Top six bits of the word select the format and operation
	// Any value not listed here decodes as an illegal instruction
	typedef enum logic [5:0] {
		OP_R2     = 6'd0,
		OP_ADDI   = 6'd1,
		OP_LOAD   = 6'd2,
		OP_STORE  = 6'd3,
		OP_BRANCH = 6'd4,
		OP_PFX    = 6'd5,
		OP_NOP    = 6'd6
	} opcodeE;

	// ====================
	// R2 function codes
	// ====================

	// Low eleven bits of an R2 word pick the register-register operation
	// Unlisted codes are illegal, like unknown opcodes
	typedef enum logic [10:0] {
		FN_ADD = 11'd0,
		FN_SUB = 11'd1,
		FN_AND = 11'd2,
		FN_OR  = 11'd3,
		FN_XOR = 11'd4
	} funcE;

	// Operation handed to the execute stage
	// ALU_NONE marks anything that does not use the ALU at all
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NONE
	} aluOpE;

	// ====================
	// Instruction views
	// ====================

	// Register-register layout, with the target first and two sources
	typedef struct packed {
		opcodeE                opcode;
		logic [REG_BITS-1:0]   rt;
		logic [REG_BITS-1:0]   ra;
		logic [REG_BITS-1:0]   rb;
		funcE                  func;
	} r2FormatS;

	// Immediate layout, where the low half word is a constant
	// A PFX word uses this same layout and carries upper immediate bits here
	typedef struct packed {
		opcodeE                opcode;
		logic [REG_BITS-1:0]   rt;
		logic [REG_BITS-1:0]   ra;
		logic [15:0]           imm;
	} immFormatS;

	// The same 32 bits seen both ways, the opcode lines up in both views
	typedef union packed {
		r2FormatS  r2;
		immFormatS imm;
	} instrU;

endpackage

//--- rtl/regDecoder.sv
// Combinational register field decoder, gives sources, target, zero flags and the write enable
`timescale 1ns/1ps

module regDecoder (
	input  decodePkg::instrU                    instr,
	output logic [decodePkg::REG_BITS-1:0]      ra,
	output logic [decodePkg::REG_BITS-1:0]      rb,
	output logic [decodePkg::REG_BITS-1:0]      rt,
	output logic                                raz,
	output logic                                rbz,
	output logic                                writeEn
);

	// Raised for the formats that write a result register
	logic writesRt;

	// ====================
	// Field selection
	// ====================

	always_comb begin
		// Default covers NOP, PFX and every illegal opcode
		ra       = '0;
		rb       = '0;
		rt       = '0;
		writesRt = 1'b0;
		case (instr.r2.opcode)
			decodePkg::OP_R2: begin
				// Two sources and one target, all from the R2 view
				ra       = instr.r2.ra;
				rb       = instr.r2.rb;
				rt       = instr.r2.rt;
				writesRt = 1'b1;
			end
			decodePkg::OP_ADDI,
			decodePkg::OP_LOAD: begin
				// One source, the second operand is the immediate
				ra       = instr.imm.ra;
				rt       = instr.imm.rt;
				writesRt = 1'b1;
			end
			decodePkg::OP_STORE,
			decodePkg::OP_BRANCH: begin
				// The rt slot names a second source here, store data or compare operand
				ra = instr.imm.ra;
				rb = instr.imm.rt;
			end
			default: begin
				// Nothing read and nothing written
			end
		endcase
	end

	// ====================
	// Flags
	// ====================

	// Register zero reads as the constant zero
	assign raz = (ra == '0);
	assign rbz = (rb == '0);

	// Writes aimed at register zero are thrown away here, so later stages never see them
	assign writeEn = writesRt && (rt != '0);

endmodule

//--- rtl/immDecoder.sv
// Combinational immediate decoder with sign extension and merging of a pending prefix
`timescale 1ns/1ps

module immDecoder #(
	parameter int XLEN = 32
) (
	input  decodePkg::instrU    instr,
	input  logic                pfxValid,
	input  logic [15:0]         pfxBits,
	output logic [XLEN-1:0]     imm,
	output logic                hasImm,
	output logic                badPfx
);

	// Immediate before widening, always 32 bits
	logic signed [31:0] imm32;
	// The current word is itself a prefix
	logic isPfxWord;

	assign isPfxWord = (instr.imm.opcode == decodePkg::OP_PFX);

	// Only the four immediate formats carry a constant
	always_comb begin
		case (instr.imm.opcode)
			decodePkg::OP_ADDI,
			decodePkg::OP_LOAD,
			decodePkg::OP_STORE,
			decodePkg::OP_BRANCH: hasImm = 1'b1;
			default:              hasImm = 1'b0;
		endcase
	end

	// ====================
	// Value formation
	// ====================

	always_comb begin
		if (!hasImm) begin
			imm32 = '0;
		end else if (pfxValid) begin
			// Prefix supplies the upper half, the field the lower half
			imm32 = {pfxBits, instr.imm.imm};
		end else begin
			// Plain 16 bit constant, sign extended to 32 first
			imm32 = {{16{instr.imm.imm[15]}}, instr.imm.imm};
		end
	end

	// Signed size cast widens from bit 31 when XLEN is 64
	assign imm = XLEN'(imm32);

	// A prefix is wasted when the next word has nowhere to put it
	// Another PFX is fine since it just replaces the pending bits
	assign badPfx = pfxValid && !isPfxWord && !hasImm;

endmodule

//--- rtl/opClassDecoder.sv
// Combinational class decoder, gives the ALU operation, class flags and illegal detection
`timescale 1ns/1ps

module opClassDecoder (
	input  decodePkg::instrU    instr,
	input  logic                immSign,
	output decodePkg::aluOpE    aluOp,
	output logic                isAlu,
	output logic                isLoad,
	output logic                isStore,
	output logic                isMem,
	output logic                isBranch,
	output logic                isBackBranch,
	output logic                isPfx,
	output logic                illegal
);

	// ====================
	// Opcode and function decode
	// ====================

	always_comb begin
		// Everything off by default, an illegal word only raises illegal
		aluOp    = decodePkg::ALU_NONE;
		isAlu    = 1'b0;
		isLoad   = 1'b0;
		isStore  = 1'b0;
		isBranch = 1'b0;
		isPfx    = 1'b0;
		illegal  = 1'b0;
		case (instr.r2.opcode)
			decodePkg::OP_R2: begin
				isAlu = 1'b1;
				case (instr.r2.func)
					decodePkg::FN_ADD: aluOp = decodePkg::ALU_ADD;
					decodePkg::FN_SUB: aluOp = decodePkg::ALU_SUB;
					decodePkg::FN_AND: aluOp = decodePkg::ALU_AND;
					decodePkg::FN_OR:  aluOp = decodePkg::ALU_OR;
					decodePkg::FN_XOR: aluOp = decodePkg::ALU_XOR;
					default: begin
						// Unknown function code, take back the ALU class
						isAlu   = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			decodePkg::OP_ADDI: begin
				aluOp = decodePkg::ALU_ADD;
				isAlu = 1'b1;
			end
			decodePkg::OP_LOAD: begin
				// The ALU forms the address as base plus offset
				aluOp  = decodePkg::ALU_ADD;
				isLoad = 1'b1;
			end
			decodePkg::OP_STORE: begin
				aluOp   = decodePkg::ALU_ADD;
				isStore = 1'b1;
			end
			decodePkg::OP_BRANCH: begin
				// Compare and target math live in the branch unit
				isBranch = 1'b1;
			end
			decodePkg::OP_PFX: begin
				isPfx = 1'b1;
			end
			decodePkg::OP_NOP: begin
				// No class at all
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

	// ====================
	// Derived flags
	// ====================

	assign isMem = isLoad || isStore;

	// Sign of the final immediate, so a merged prefix counts too
	assign isBackBranch = isBranch && immSign;

endmodule

//--- rtl/prefixTracker.sv
// Two-state machine that holds prefix bits until the next accepted instruction uses them
`timescale 1ns/1ps

module prefixTracker (
	input  logic        clk,
	input  logic        rst,
	input  logic        accept,
	input  logic        isPfx,
	input  logic [15:0] pfxIn,
	output logic        pfxValid,
	output logic [15:0] pfxBits
);

	// State encoding
	localparam logic IDLE    = 1'b0;
	localparam logic PENDING = 1'b1;

	logic state;
	logic stateNext;

	// ====================
	// Next state
	// ====================

	always_comb begin
		stateNext = state;
		// Only accepted words move the machine, stalls leave it alone
		if (accept) begin
			if (isPfx) begin
				stateNext = PENDING;
			end else begin
				// Any other word consumes or discards the prefix
				stateNext = IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= stateNext;
		end
	end

	// Prefix payload, a second PFX simply overwrites it
	always_ff @(posedge clk) begin
		if (accept && isPfx) begin
			pfxBits <= pfxIn;
		end
	end

	// The bits only matter while PENDING
	assign pfxValid = (state == PENDING);

endmodule

//--- rtl/decodeStage.sv
// Valid/ready output register of the decode stage, drops prefix words and holds under stall
`timescale 1ns/1ps

module decodeStage #(
	parameter int XLEN = 32
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                inValid,
	input  logic                                outReady,
	// Decoder results for the word on the input
	input  logic [decodePkg::REG_BITS-1:0]      raIn,
	input  logic [decodePkg::REG_BITS-1:0]      rbIn,
	input  logic [decodePkg::REG_BITS-1:0]      rtIn,
	input  logic                                razIn,
	input  logic                                rbzIn,
	input  logic                                writeEnIn,
	input  logic [XLEN-1:0]                     immIn,
	input  logic                                hasImmIn,
	input  logic                                badPfxIn,
	input  decodePkg::aluOpE                    aluOpIn,
	input  logic                                isAluIn,
	input  logic                                isLoadIn,
	input  logic                                isStoreIn,
	input  logic                                isMemIn,
	input  logic                                isBranchIn,
	input  logic                                isBackBranchIn,
	input  logic                                isPfx,
	input  logic                                illegalIn,
	// Stream handshake
	output logic                                inReady,
	output logic                                outValid,
	// Registered result
	output logic [decodePkg::REG_BITS-1:0]      ra,
	output logic [decodePkg::REG_BITS-1:0]      rb,
	output logic [decodePkg::REG_BITS-1:0]      rt,
	output logic                                raz,
	output logic                                rbz,
	output logic                                writeEn,
	output logic [XLEN-1:0]                     imm,
	output logic                                hasImm,
	output logic                                badPfx,
	output decodePkg::aluOpE                    aluOp,
	output logic                                isAlu,
	output logic                                isLoad,
	output logic                                isStore,
	output logic                                isMem,
	output logic                                isBranch,
	output logic                                isBackBranch,
	output logic                                illegal
);

	logic accept;
	logic capture;

	// ====================
	// Handshake
	// ====================

	// Room exists when the register is empty or is being emptied this cycle
	assign inReady = !outValid || outReady;
	assign accept  = inValid && inReady;
	// Prefix words are taken from the stream but never stored
	assign capture = accept && !isPfx;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (capture) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			// Result taken and nothing new behind it
			outValid <= 1'b0;
		end
	end

	// ====================
	// Result register
	// ====================

	// Loads only on capture, so every field holds while stalled
	always_ff @(posedge clk) begin
		if (capture) begin
			ra           <= raIn;
			rb           <= rbIn;
			rt           <= rtIn;
			raz          <= razIn;
			rbz          <= rbzIn;
			writeEn      <= writeEnIn;
			imm          <= immIn;
			hasImm       <= hasImmIn;
			badPfx       <= badPfxIn;
			aluOp        <= aluOpIn;
			isAlu        <= isAluIn;
			isLoad       <= isLoadIn;
			isStore      <= isStoreIn;
			isMem        <= isMemIn;
			isBranch     <= isBranchIn;
			isBackBranch <= isBackBranchIn;
			illegal      <= illegalIn;
		end
	end

endmodule

//--- rtl/decodeUnit.sv
// Top of the decode stage, joins the field decoders, the prefix tracker and the output register
`timescale 1ns/1ps

module decodeUnit #(
	parameter int XLEN = 32
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                inValid,
	input  decodePkg::instrU                    instr,
	input  logic                                outReady,
	output logic                                inReady,
	output logic                                outValid,
	output logic [decodePkg::REG_BITS-1:0]      ra,
	output logic [decodePkg::REG_BITS-1:0]      rb,
	output logic [decodePkg::REG_BITS-1:0]      rt,
	output logic                                raz,
	output logic                                rbz,
	output logic                                writeEn,
	output logic [XLEN-1:0]                     imm,
	output logic                                hasImm,
	output logic                                badPfx,
	output decodePkg::aluOpE                    aluOp,
	output logic                                isAlu,
	output logic                                isLoad,
	output logic                                isStore,
	output logic                                isMem,
	output logic                                isBranch,
	output logic                                isBackBranch,
	output logic                                illegal
);

	// ====================
	// Decoder results
	// ====================

	logic [decodePkg::REG_BITS-1:0] decRa;
	logic [decodePkg::REG_BITS-1:0] decRb;
	logic [decodePkg::REG_BITS-1:0] decRt;
	logic                           decRaz;
	logic                           decRbz;
	logic                           decWriteEn;
	logic [XLEN-1:0]                decImm;
	logic                           decHasImm;
	logic                           decBadPfx;
	decodePkg::aluOpE               decAluOp;
	logic                           decIsAlu;
	logic                           decIsLoad;
	logic                           decIsStore;
	logic                           decIsMem;
	logic                           decIsBranch;
	logic                           decIsBackBranch;
	logic                           decIsPfx;
	logic                           decIllegal;

	// Prefix state seen by the immediate decoder
	logic        pfxValid;
	logic [15:0] pfxBits;
	logic        accept;

	// Same handshake the output stage uses, the tracker moves on every accept
	assign accept = inValid && inReady;

	regDecoder uRegDec (
		.instr   (instr),
		.ra      (decRa),
		.rb      (decRb),
		.rt      (decRt),
		.raz     (decRaz),
		.rbz     (decRbz),
		.writeEn (decWriteEn)
	);

	immDecoder #(
		.XLEN (XLEN)
	) uImmDec (
		.instr    (instr),
		.pfxValid (pfxValid),
		.pfxBits  (pfxBits),
		.imm      (decImm),
		.hasImm   (decHasImm),
		.badPfx   (decBadPfx)
	);

	// Branch direction comes from the top bit of the final immediate
	opClassDecoder uClassDec (
		.instr        (instr),
		.immSign      (decImm[XLEN-1]),
		.aluOp        (decAluOp),
		.isAlu        (decIsAlu),
		.isLoad       (decIsLoad),
		.isStore      (decIsStore),
		.isMem        (decIsMem),
		.isBranch     (decIsBranch),
		.isBackBranch (decIsBackBranch),
		.isPfx        (decIsPfx),
		.illegal      (decIllegal)
	);

	prefixTracker uPfx (
		.clk      (clk),
		.rst      (rst),
		.accept   (accept),
		.isPfx    (decIsPfx),
		.pfxIn    (instr.imm.imm),
		.pfxValid (pfxValid),
		.pfxBits  (pfxBits)
	);

	// ====================
	// Output register
	// ====================

	decodeStage #(
		.XLEN (XLEN)
	) uStage (
		.clk            (clk),
		.rst            (rst),
		.inValid        (inValid),
		.outReady       (outReady),
		.raIn           (decRa),
		.rbIn           (decRb),
		.rtIn           (decRt),
		.razIn          (decRaz),
		.rbzIn          (decRbz),
		.writeEnIn      (decWriteEn),
		.immIn          (decImm),
		.hasImmIn       (decHasImm),
		.badPfxIn       (decBadPfx),
		.aluOpIn        (decAluOp),
		.isAluIn        (decIsAlu),
		.isLoadIn       (decIsLoad),
		.isStoreIn      (decIsStore),
		.isMemIn        (decIsMem),
		.isBranchIn     (decIsBranch),
		.isBackBranchIn (decIsBackBranch),
		.isPfx          (decIsPfx),
		.illegalIn      (decIllegal),
		.inReady        (inReady),
		.outValid       (outValid),
		.ra             (ra),
		.rb             (rb),
		.rt             (rt),
		.raz            (raz),
		.rbz            (rbz),
		.writeEn        (writeEn),
		.imm            (imm),
		.hasImm         (hasImm),
		.badPfx         (badPfx),
		.aluOp          (aluOp),
		.isAlu          (isAlu),
		.isLoad         (isLoad),
		.isStore        (isStore),
		.isMem          (isMem),
		.isBranch       (isBranch),
		.isBackBranch   (isBackBranch),
		.illegal        (illegal)
	);

endmodule

//--- test/decodeModel.svh
// Reference decode model, LFSR and random instruction generator, included inside the decode unit testbench
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// One decode result with a field for every DUT output
// The same layout holds expected values and sampled outputs
typedef struct packed {
	logic [4:0]  ra;
	logic [4:0]  rb;
	logic [4:0]  rt;
	logic        raz;
	logic        rbz;
	logic        writeEn;
	logic [31:0] imm;
	logic        hasImm;
	logic        badPfx;
	logic [2:0]  aluOp;
	logic        isAlu;
	logic        isLoad;
	logic        isStore;
	logic        isMem;
	logic        isBranch;
	logic        isBackBranch;
	logic        illegal;
} resultS;

// Random state, moved on by one step for every bit handed out
logic [31:0] lfsr;

// ====================
// Random source
// ====================

// Fibonacci LFSR with taps 32, 22, 2 and 1, the new bit is also the bit returned
task automatic takeBits(input int count, output logic [31:0] bits);
	logic fb;
	bits = '0;
	for (int i = 0; i < count; i++) begin
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		bits = {bits[30:0], fb};
	end
endtask

// Register number with about one chance in eight of being register zero
task automatic pickReg(output logic [4:0] r);
	logic [31:0] bits;
	takeBits(3, bits);
	if (bits[2:0] == 3'd0) begin
		r = 5'd0;
	end else begin
		takeBits(5, bits);
		r = bits[4:0];
	end
endtask

// Random word with weighted opcodes
// PFX is common enough to give runs of prefixes, the last slot gives illegal opcodes
task automatic makeInstr(output logic [31:0] w);
	logic [31:0] bits;
	logic [5:0]  op;
	logic [4:0]  rt;
	logic [4:0]  ra;
	logic [4:0]  rb;
	logic [15:0] field;
	logic [10:0] func;
	pickReg(rt);
	pickReg(ra);
	pickReg(rb);
	takeBits(16, bits);
	field = bits[15:0];
	takeBits(4, bits);
	case (bits[3:0])
		4'd0, 4'd1, 4'd2: op = decodePkg::OP_R2;
		4'd3, 4'd4:       op = decodePkg::OP_ADDI;
		4'd5, 4'd6:       op = decodePkg::OP_LOAD;
		4'd7:             op = decodePkg::OP_STORE;
		4'd8, 4'd9:       op = decodePkg::OP_BRANCH;
		4'd10, 4'd11:     op = decodePkg::OP_PFX;
		4'd12, 4'd13:     op = decodePkg::OP_NOP;
		default: begin
			// Fold the low codes up so every pick lands on an unused opcode
			takeBits(6, bits);
			op = (bits[5:0] < 6'd7) ? bits[5:0] + 6'd7 : bits[5:0];
		end
	endcase
	if (op == decodePkg::OP_R2) begin
		// Mostly legal function codes, otherwise any eleven bits
		takeBits(3, bits);
		if (bits[2:0] < 3'd5) begin
			func = {8'd0, bits[2:0]};
		end else begin
			takeBits(11, bits);
			func = bits[10:0];
		end
		w = {op, rt, ra, rb, func};
	end else begin
		w = {op, rt, ra, field};
	end
endtask

// ====================
// Decode rules
// ====================

// Expected result of one accepted word given the model prefix state before the accept
function automatic resultS decodeWord(input logic [31:0] w, input logic pfxValid,
		input logic [15:0] pfxBits);
	resultS      r;
	logic [5:0]  op;
	logic        writes;
	r = '0;
	op = w[31:26];
	writes = 1'b0;
	r.aluOp = decodePkg::ALU_NONE;
	// Register use depends only on the opcode
	if (op == decodePkg::OP_R2) begin
		r.rt = w[25:21];
		r.ra = w[20:16];
		r.rb = w[15:11];
		writes = 1'b1;
	end else if (op == decodePkg::OP_ADDI || op == decodePkg::OP_LOAD) begin
		r.rt = w[25:21];
		r.ra = w[20:16];
		writes = 1'b1;
	end else if (op == decodePkg::OP_STORE || op == decodePkg::OP_BRANCH) begin
		// The rt slot is read as the second source
		r.ra = w[20:16];
		r.rb = w[25:21];
	end
	r.raz = (r.ra == 5'd0);
	r.rbz = (r.rb == 5'd0);
	r.writeEn = writes && (r.rt != 5'd0);
	// Immediate formats, merged with a pending prefix when there is one
	r.hasImm = (op == decodePkg::OP_ADDI) || (op == decodePkg::OP_LOAD) ||
		(op == decodePkg::OP_STORE) || (op == decodePkg::OP_BRANCH);
	if (r.hasImm && pfxValid) begin
		r.imm = {pfxBits, w[15:0]};
	end else if (r.hasImm) begin
		r.imm = {{16{w[15]}}, w[15:0]};
	end
	r.badPfx = pfxValid && !r.hasImm && (op != decodePkg::OP_PFX);
	// Class flags
	if (op == decodePkg::OP_R2) begin
		case (w[10:0])
			11'd0:   r.aluOp = decodePkg::ALU_ADD;
			11'd1:   r.aluOp = decodePkg::ALU_SUB;
			11'd2:   r.aluOp = decodePkg::ALU_AND;
			11'd3:   r.aluOp = decodePkg::ALU_OR;
			11'd4:   r.aluOp = decodePkg::ALU_XOR;
			default: r.illegal = 1'b1;
		endcase
		r.isAlu = !r.illegal;
	end else if (op == decodePkg::OP_ADDI) begin
		r.aluOp = decodePkg::ALU_ADD;
		r.isAlu = 1'b1;
	end else if (op == decodePkg::OP_LOAD || op == decodePkg::OP_STORE) begin
		r.aluOp = decodePkg::ALU_ADD;
		r.isLoad = (op == decodePkg::OP_LOAD);
		r.isStore = (op == decodePkg::OP_STORE);
		r.isMem = 1'b1;
	end else if (op == decodePkg::OP_BRANCH) begin
		r.isBranch = 1'b1;
		r.isBackBranch = r.imm[31];
	end else if (op > decodePkg::OP_NOP) begin
		r.illegal = 1'b1;
	end
	return r;
endfunction

`endif

//--- test/tbDecodeUnit.sv
// Decode unit testbench top that checks directed prefix cases and random traffic against a model
`timescale 1ns/1ps

module tbDecodeUnit;

	localparam int XLEN        = 32;
	localparam int NUM_ACCEPTS = 2000;
	localparam int CYCLE_LIMIT = 4 * NUM_ACCEPTS + 100;

	logic             clk;
	logic             rst;
	logic             inValid;
	decodePkg::instrU instr;
	logic             outReady;
	logic             inReady;
	logic             outValid;
	logic [4:0]       ra;
	logic [4:0]       rb;
	logic [4:0]       rt;
	logic             raz;
	logic             rbz;
	logic             writeEn;
	logic [XLEN-1:0]  imm;
	logic             hasImm;
	logic             badPfx;
	decodePkg::aluOpE aluOp;
	logic             isAlu;
	logic             isLoad;
	logic             isStore;
	logic             isMem;
	logic             isBranch;
	logic             isBackBranch;
	logic             illegal;

	`include "decodeModel.svh"

	// Scoreboard and model prefix state
	resultS      expQ[$];
	resultS      heldSnap;
	logic        wasStalled;
	logic        modelPfxValid;
	logic [15:0] modelPfxBits;
	int          acceptCount;
	int          cycles;
	int          errors;
	int          checks;
	int          testErrors;

	decodeUnit #(
		.XLEN (XLEN)
	) i_dut (
		.clk          (clk),
		.rst          (rst),
		.inValid      (inValid),
		.instr        (instr),
		.outReady     (outReady),
		.inReady      (inReady),
		.outValid     (outValid),
		.ra           (ra),
		.rb           (rb),
		.rt           (rt),
		.raz          (raz),
		.rbz          (rbz),
		.writeEn      (writeEn),
		.imm          (imm),
		.hasImm       (hasImm),
		.badPfx       (badPfx),
		.aluOp        (aluOp),
		.isAlu        (isAlu),
		.isLoad       (isLoad),
		.isStore      (isStore),
		.isMem        (isMem),
		.isBranch     (isBranch),
		.isBackBranch (isBackBranch),
		.illegal      (illegal)
	);

	always #5 clk = ~clk;

	// ====================
	// Check helpers
	// ====================

	task automatic checkField(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		checks++;
		assert (actVal === expVal) else begin
			$display("Fail time %0t signal %s expected %0h actual %0h", $time, name,
				expVal, actVal);
			errors++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("Error at time %0t %s", $time, msg);
		errors++;
	endtask

	task automatic compareResult(input resultS e, input resultS a);
		checkField("ra", 32'(e.ra), 32'(a.ra));
		checkField("rb", 32'(e.rb), 32'(a.rb));
		checkField("rt", 32'(e.rt), 32'(a.rt));
		checkField("raz", 32'(e.raz), 32'(a.raz));
		checkField("rbz", 32'(e.rbz), 32'(a.rbz));
		checkField("writeEn", 32'(e.writeEn), 32'(a.writeEn));
		checkField("imm", e.imm, a.imm);
		checkField("hasImm", 32'(e.hasImm), 32'(a.hasImm));
		checkField("badPfx", 32'(e.badPfx), 32'(a.badPfx));
		checkField("aluOp", 32'(e.aluOp), 32'(a.aluOp));
		checkField("isAlu", 32'(e.isAlu), 32'(a.isAlu));
		checkField("isLoad", 32'(e.isLoad), 32'(a.isLoad));
		checkField("isStore", 32'(e.isStore), 32'(a.isStore));
		checkField("isMem", 32'(e.isMem), 32'(a.isMem));
		checkField("isBranch", 32'(e.isBranch), 32'(a.isBranch));
		checkField("isBackBranch", 32'(e.isBackBranch), 32'(a.isBackBranch));
		checkField("illegal", 32'(e.illegal), 32'(a.illegal));
	endtask

	function automatic resultS readOutputs();
		resultS r;
		r.ra = ra;
		r.rb = rb;
		r.rt = rt;
		r.raz = raz;
		r.rbz = rbz;
		r.writeEn = writeEn;
		r.imm = imm;
		r.hasImm = hasImm;
		r.badPfx = badPfx;
		r.aluOp = aluOp;
		r.isAlu = isAlu;
		r.isLoad = isLoad;
		r.isStore = isStore;
		r.isMem = isMem;
		r.isBranch = isBranch;
		r.isBackBranch = isBackBranch;
		r.illegal = illegal;
		return r;
	endfunction

	task automatic endTest(input string name);
		$display("Test %s finished with %0d errors", name, errors - testErrors);
		testErrors = errors;
	endtask

	function automatic logic [31:0] encImm(input logic [5:0] op, input logic [4:0] rtF,
			input logic [4:0] raF, input logic [15:0] field);
		return {op, rtF, raF, field};
	endfunction

	function automatic logic [31:0] encR2(input logic [4:0] rtF, input logic [4:0] raF,
			input logic [4:0] rbF, input logic [10:0] func);
		return {decodePkg::OP_R2, rtF, raF, rbF, func};
	endfunction

	// Drive one cycle of inputs just after the edge and report whether the word went in
	task automatic driveCycle(input logic valid, input logic [31:0] w, input logic ready,
			output logic taken);
		inValid = valid;
		instr = w;
		outReady = ready;
		@(negedge clk);
		taken = valid && inReady;
		@(posedge clk);
		#1;
	endtask

	// ====================
	// Monitor and scoreboard
	// ====================

	// Mid-cycle sampling sees the values that the coming edge will act on
	always @(negedge clk) begin : monitor
		resultS      seen;
		logic [31:0] word;
		logic        full;
		seen = readOutputs();
		word = instr;
		if (!rst) begin
			// The model holds an item exactly when the output register should
			full = (expQ.size() != 0);
			checkField("outValid", 32'(full), 32'(outValid));
			checkField("inReady", 32'(!full || outReady), 32'(inReady));
			// Stalled outputs must not move
			if (wasStalled) begin
				compareResult(heldSnap, seen);
			end
			if (outValid && outReady) begin
				assert (expQ.size() != 0) else begin
					reportProblem("output transfer with no accepted instruction outstanding");
				end
				if (expQ.size() != 0) begin
					compareResult(expQ.pop_front(), seen);
				end
			end
			wasStalled = full && !outReady;
			heldSnap = seen;
			if (inValid && inReady) begin
				acceptCount++;
				if (word[31:26] == decodePkg::OP_PFX) begin
					// A newer prefix replaces any pending one
					modelPfxValid = 1'b1;
					modelPfxBits = word[15:0];
				end else begin
					expQ.push_back(decodeWord(word, modelPfxValid, modelPfxBits));
					modelPfxValid = 1'b0;
				end
			end
		end
	end

	// Watchdog on the total cycle count
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d instructions accepted", cycles,
				acceptCount);
			$display("Some tests failed");
			$finish;
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin : stimulus
		logic [31:0] directed[$];
		logic [31:0] bits;
		logic [31:0] word;
		logic        validBit;
		logic        readyBit;
		logic        taken;
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		lfsr = 32'h1597;
		errors = 0;
		checks = 0;
		testErrors = 0;
		cycles = 0;
		acceptCount = 0;
		modelPfxValid = 1'b0;
		modelPfxBits = '0;
		wasStalled = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// Empty stage and no pending prefix right after reset
		@(negedge clk);
		checkField("outValid", 32'd0, 32'(outValid));
		checkField("inReady", 32'd1, 32'(inReady));
		@(posedge clk);
		#1;
		endTest("reset state");

		// First word is negative and must not pick up stale prefix bits
		directed.push_back(encImm(decodePkg::OP_ADDI, 5'd1, 5'd2, 16'hFFF0));
		directed.push_back(encImm(decodePkg::OP_BRANCH, 5'd3, 5'd4, 16'h8000));
		directed.push_back(encImm(decodePkg::OP_PFX, 5'd0, 5'd0, 16'h1234));
		directed.push_back(encImm(decodePkg::OP_ADDI, 5'd5, 5'd0, 16'h5678));
		// Second prefix wins over the first
		directed.push_back(encImm(decodePkg::OP_PFX, 5'd0, 5'd0, 16'hAAAA));
		directed.push_back(encImm(decodePkg::OP_PFX, 5'd0, 5'd0, 16'h8001));
		directed.push_back(encImm(decodePkg::OP_BRANCH, 5'd6, 5'd7, 16'h0004));
		// Prefix wasted on a word with no immediate
		directed.push_back(encImm(decodePkg::OP_PFX, 5'd0, 5'd0, 16'h0001));
		directed.push_back(encImm(decodePkg::OP_NOP, 5'd9, 5'd9, 16'h0000));
		directed.push_back(encImm(decodePkg::OP_ADDI, 5'd0, 5'd1, 16'h0002));
		directed.push_back(encImm(decodePkg::OP_LOAD, 5'd8, 5'd9, 16'h7FFF));
		directed.push_back(encImm(decodePkg::OP_STORE, 5'd10, 5'd0, 16'h8001));
		directed.push_back(encR2(5'd11, 5'd12, 5'd13, decodePkg::FN_ADD));
		directed.push_back(encR2(5'd0, 5'd12, 5'd0, decodePkg::FN_SUB));
		directed.push_back(encR2(5'd14, 5'd0, 5'd15, decodePkg::FN_AND));
		directed.push_back(encR2(5'd16, 5'd17, 5'd18, decodePkg::FN_OR));
		directed.push_back(encR2(5'd19, 5'd20, 5'd21, decodePkg::FN_XOR));
		directed.push_back(encR2(5'd1, 5'd2, 5'd3, 11'd9));
		directed.push_back(encImm(6'd7, 5'd1, 5'd2, 16'h1111));
		directed.push_back(encImm(6'd63, 5'd1, 5'd2, 16'hFFFF));
		directed.push_back(encImm(decodePkg::OP_PFX, 5'd0, 5'd0, 16'h0F0F));
		directed.push_back(encR2(5'd4, 5'd5, 5'd6, decodePkg::FN_ADD));
		foreach (directed[i]) begin
			taken = 1'b0;
			while (!taken) begin
				driveCycle(1'b1, directed[i], 1'b1, taken);
			end
		end
		repeat (3) driveCycle(1'b0, 32'd0, 1'b1, taken);
		endTest("directed decode and prefixes");

		// Random valid and ready where a refused word stays on the input until taken
		taken = 1'b1;
		validBit = 1'b0;
		word = '0;
		while (acceptCount < NUM_ACCEPTS) begin
			if (taken || !validBit) begin
				takeBits(2, bits);
				validBit = (bits[1:0] != 2'd0);
				makeInstr(word);
			end
			takeBits(2, bits);
			readyBit = (bits[1:0] != 2'd0);
			driveCycle(validBit, word, readyBit, taken);
		end
		repeat (3) driveCycle(1'b0, word, 1'b1, taken);
		endTest("random traffic with back-pressure");

		assert (expQ.size() == 0) else begin
			reportProblem($sformatf("%0d accepted instructions never came out", expQ.size()));
		end
		endTest("drain");

		$display("Checks %0d, errors %0d, accepted %0d", checks, errors, acceptCount);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+test
rtl/decodePkg.sv
rtl/regDecoder.sv
rtl/immDecoder.sv
rtl/opClassDecoder.sv
rtl/prefixTracker.sv
rtl/decodeStage.sv
rtl/decodeUnit.sv
test/tbDecodeUnit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tbDecodeUnit -o tbDecodeUnit
output=$(./obj_dir/tbDecodeUnit)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1
